// ==== logic/pe_pkg.sv ====
package pe_pkg;

    // value and coordinate widths
    localparam int WORD_W = 8;
    localparam int COORD_W = 8;

    // weights per pass, entries per feature group
    localparam int MATRIX_W = 4;

    localparam int PROD_W = 2 * WORD_W;

    // weight slot index
    localparam int SLOT_W = (MATRIX_W > 1) ? $clog2(MATRIX_W) : 1;

    typedef logic signed [WORD_W-1:0] word_t;
    typedef logic signed [COORD_W-1:0] coord_t;
    typedef logic signed [PROD_W-1:0] prod_t;
    typedef logic [SLOT_W-1:0] slot_t;

    localparam slot_t LAST_SLOT = slot_t'(MATRIX_W - 1);

    // one weight or one feature
    typedef struct packed {
        word_t value;
        coord_t row;
        coord_t col;
    } entry_t;

    typedef entry_t [MATRIX_W-1:0] group_t;

    // product plus feature-minus-weight offsets
    typedef struct packed {
        prod_t prod;
        coord_t row_off;
        coord_t col_off;
    } result_t;

    // [weight i][entry j]
    typedef result_t [MATRIX_W-1:0][MATRIX_W-1:0] result_array_t;

    typedef enum logic {
        LOAD_WEIGHT,
        STREAM
    } pe_state_t;

endpackage

// ==== logic/pe_decode.sv ====
`timescale 1ns/10ps

module pe_decode #(
    parameter int COUNT_W = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  logic [COUNT_W-1:0]  feature_count,
    output logic                weight_we,
    output pe_pkg::slot_t       weight_slot,
    output logic                shift_en,
    output logic                clear,
    output logic                issue
);

    pe_pkg::pe_state_t state;
    pe_pkg::slot_t slot_cnt;
    logic [COUNT_W-1:0] grp_cnt;
    logic [COUNT_W-1:0] last_grp;

    logic last_weight;
    logic last_group;

    assign last_grp = feature_count - 1'b1;
    assign last_weight = (slot_cnt == pe_pkg::LAST_SLOT);
    assign last_group = (grp_cnt == last_grp);

    // weight phase strobes
    assign weight_we = in_valid && (state == pe_pkg::LOAD_WEIGHT);
    assign weight_slot = slot_cnt;

    // first weight of a pass wipes the old window
    assign clear = weight_we && (slot_cnt == '0);

    // stream phase strobes
    assign shift_en = in_valid && (state == pe_pkg::STREAM);
    assign issue = shift_en;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= pe_pkg::LOAD_WEIGHT;
            slot_cnt <= '0;
            grp_cnt <= '0;
        end else begin
            if (weight_we) begin
                if (last_weight) begin
                    slot_cnt <= '0;
                    state <= pe_pkg::STREAM;
                end else begin
                    slot_cnt <= slot_cnt + 1'b1;
                end
            end

            if (shift_en) begin
                // back to weights after the last group
                if (last_group) begin
                    grp_cnt <= '0;
                    state <= pe_pkg::LOAD_WEIGHT;
                end else begin
                    grp_cnt <= grp_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/pe_operand_store.sv ====
`timescale 1ns/10ps

module pe_operand_store (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        weight_we,
    input  pe_pkg::slot_t                               weight_slot,
    input  logic                                        shift_en,
    input  logic                                        clear,
    input  pe_pkg::entry_t                              weight_in,
    input  pe_pkg::group_t                              group_in,
    output pe_pkg::entry_t [pe_pkg::MATRIX_W-1:0]       weights,
    output pe_pkg::group_t [pe_pkg::MATRIX_W-1:0]       window
);

    // weight registers, one per slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            weights <= '0;
        end else if (weight_we) begin
            weights[weight_slot] <= weight_in;
        end
    end

    // slot 0 newest, oldest group drops off the top
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            window <= '0;
        end else if (clear || shift_en) begin
            for (int s = pe_pkg::MATRIX_W - 1; s > 0; s--) begin
                window[s] <= clear ? '0 : window[s-1];
            end
            // with clear, new group lands in front of zeros
            window[0] <= shift_en ? group_in : '0;
        end
    end

endmodule

// ==== logic/pe_execute.sv ====
`timescale 1ns/10ps

module pe_execute (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        issue,
    input  pe_pkg::entry_t [pe_pkg::MATRIX_W-1:0]       weights,
    input  pe_pkg::group_t [pe_pkg::MATRIX_W-1:0]       window,
    output logic                                        out_valid,
    output pe_pkg::result_array_t                       results
);

    logic issue_q;
    pe_pkg::result_array_t next_results;

    // weight i pairs with window slot i
    always_comb begin
        for (int i = 0; i < pe_pkg::MATRIX_W; i++) begin
            for (int j = 0; j < pe_pkg::MATRIX_W; j++) begin
                next_results[i][j].prod =
                    $signed(weights[i].value) * $signed(window[i][j].value);
                // offsets wrap at coordinate width
                next_results[i][j].row_off = window[i][j].row - weights[i].row;
                next_results[i][j].col_off = window[i][j].col - weights[i].col;
            end
        end
    end

    // window settles one edge after issue
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_q <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            issue_q <= issue;
            out_valid <= issue_q;
        end
    end

    // held until the next group
    always_ff @(posedge clk) begin
        if (issue_q) begin
            results <= next_results;
        end
    end

endmodule

// ==== logic/sparse_conv_pe.sv ====
`timescale 1ns/10ps

module sparse_conv_pe #(
    parameter int COUNT_W = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  pe_pkg::entry_t          weight_in,
    input  pe_pkg::group_t          group_in,
    input  logic [COUNT_W-1:0]      feature_count,
    output logic                    out_valid,
    output pe_pkg::result_array_t   results
);

    logic weight_we;
    pe_pkg::slot_t weight_slot;
    logic shift_en;
    logic clear;
    logic issue;

    pe_pkg::entry_t [pe_pkg::MATRIX_W-1:0] weights;
    pe_pkg::group_t [pe_pkg::MATRIX_W-1:0] window;

    pe_decode #(
        .COUNT_W(COUNT_W)
    ) decode_i (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .feature_count(feature_count),
        .weight_we(weight_we),
        .weight_slot(weight_slot),
        .shift_en(shift_en),
        .clear(clear),
        .issue(issue)
    );

    pe_operand_store store_i (
        .clk(clk),
        .rst(rst),
        .weight_we(weight_we),
        .weight_slot(weight_slot),
        .shift_en(shift_en),
        .clear(clear),
        .weight_in(weight_in),
        .group_in(group_in),
        .weights(weights),
        .window(window)
    );

    pe_execute execute_i (
        .clk(clk),
        .rst(rst),
        .issue(issue),
        .weights(weights),
        .window(window),
        .out_valid(out_valid),
        .results(results)
    );

endmodule

// ==== testbench/pe_props.sv ====
`timescale 1ns/10ps

module pe_props #(
    parameter int COUNT_W = 16
) (
    input logic                 clk,
    input logic                 rst,
    input logic                 shift_en,
    input logic                 issue,
    input logic                 out_valid,
    input logic [COUNT_W-1:0]   feature_count
);

    // zero groups per pass is not a legal setting
    count_nonzero: assert property (@(posedge clk) disable iff (rst)
        shift_en |-> feature_count != '0)
        else $error("feature_count is zero while streaming");

    issue_gives_pulse: assert property (@(posedge clk) disable iff (rst)
        $past(issue, 2) |-> out_valid)
        else $error("no out_valid two cycles after issue");

    pulse_has_issue: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(issue, 2))
        else $error("out_valid without an issue two cycles earlier");

endmodule

bind sparse_conv_pe pe_props #(
    .COUNT_W(COUNT_W)
) props_i (
    .clk(clk),
    .rst(rst),
    .shift_en(shift_en),
    .issue(issue),
    .out_valid(out_valid),
    .feature_count(feature_count)
);

// ==== testbench/tb_sparse_conv_pe.sv ====
`timescale 1ns/10ps

module tb_sparse_conv_pe;

    localparam int COUNT_W = 16;
    localparam int DATA_DEPTH = 512;
    localparam int ENTRY_WORDS = 3;

    logic clk;
    logic rst;
    logic in_valid;
    pe_pkg::entry_t weight_in;
    pe_pkg::group_t group_in;
    logic [COUNT_W-1:0] feature_count;
    logic out_valid;
    pe_pkg::result_array_t results;

    logic [31:0] data_mem [0:DATA_DEPTH-1];
    integer seed;
    int cycle = 0;
    int ptr;
    int pass_num;
    int pass_pulses;
    int pass_sum;
    int check_errors = 0;
    int other_errors = 0;
    int watchdog_cycles = 0;

    // reference copy of the operand registers
    pe_pkg::entry_t model_weights [pe_pkg::MATRIX_W];
    pe_pkg::group_t model_window [pe_pkg::MATRIX_W];

    // one entry per group in flight
    pe_pkg::result_array_t exp_q [$];
    int cyc_q [$];
    string tag_q [$];

    sparse_conv_pe #(
        .COUNT_W(COUNT_W)
    ) dut_i (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .weight_in(weight_in),
        .group_in(group_in),
        .feature_count(feature_count),
        .out_valid(out_valid),
        .results(results)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            check_errors++;
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    function automatic pe_pkg::entry_t make_entry(input int base);
        pe_pkg::entry_t e;
        e.value = data_mem[base][pe_pkg::WORD_W-1:0];
        e.row = data_mem[base + 1][pe_pkg::COORD_W-1:0];
        e.col = data_mem[base + 2][pe_pkg::COORD_W-1:0];
        return e;
    endfunction

    function automatic pe_pkg::entry_t random_entry();
        pe_pkg::entry_t e;
        logic [31:0] r;
        r = $random(seed);
        e.value = r[7:0];
        e.row = r[15:8];
        e.col = r[23:16];
        return e;
    endfunction

    function automatic pe_pkg::group_t random_group();
        pe_pkg::group_t g;
        for (int j = 0; j < pe_pkg::MATRIX_W; j++) begin
            g[j] = random_entry();
        end
        return g;
    endfunction

    // product and offsets worked out in plain integers, then wrapped
    function automatic pe_pkg::result_array_t expected_results();
        pe_pkg::result_array_t r;
        int p;
        int dr;
        int dc;
        for (int i = 0; i < pe_pkg::MATRIX_W; i++) begin
            for (int j = 0; j < pe_pkg::MATRIX_W; j++) begin
                p = int'(model_weights[i].value) * int'(model_window[i][j].value);
                dr = int'(model_window[i][j].row) - int'(model_weights[i].row);
                dc = int'(model_window[i][j].col) - int'(model_weights[i].col);
                r[i][j].prod = p[pe_pkg::PROD_W-1:0];
                r[i][j].row_off = dr[pe_pkg::COORD_W-1:0];
                r[i][j].col_off = dc[pe_pkg::COORD_W-1:0];
            end
        end
        return r;
    endfunction

    function automatic int count_records();
        int p;
        int n;
        int fc;
        p = 0;
        n = 0;
        while (p + 4 <= DATA_DEPTH && data_mem[p] != 0) begin
            fc = data_mem[p];
            n += pe_pkg::MATRIX_W + fc;
            p += 4 + ENTRY_WORDS * pe_pkg::MATRIX_W * (1 + fc);
        end
        return n;
    endfunction

    // data inputs carry junk whenever they should be ignored
    task automatic idle_cycle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        weight_in = random_entry();
        group_in = random_group();
    endtask

    task automatic insert_gap(input int gap_max);
        int n;
        n = 0;
        if (gap_max > 0) begin
            n = $unsigned($random(seed)) % (gap_max + 1);
        end
        repeat (n) idle_cycle();
    endtask

    task automatic drive_weight(input int slot, input pe_pkg::entry_t e);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        weight_in = e;
        group_in = random_group();
        if (slot == 0) begin
            for (int s = 0; s < pe_pkg::MATRIX_W; s++) begin
                model_window[s] = '0;
            end
        end
        model_weights[slot] = e;
    endtask

    task automatic drive_group(input pe_pkg::group_t g, input string tag);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        group_in = g;
        weight_in = random_entry();
        for (int s = pe_pkg::MATRIX_W - 1; s > 0; s--) begin
            model_window[s] = model_window[s-1];
        end
        model_window[0] = g;
        exp_q.push_back(expected_results());
        // sampled at this cycle's edge, visible two cycles on
        cyc_q.push_back(cycle + 2);
        tag_q.push_back(tag);
    endtask

    task automatic check_pulse();
        pe_pkg::result_array_t exp_r;
        int exp_cyc;
        string tag;
        exp_r = exp_q.pop_front();
        exp_cyc = cyc_q.pop_front();
        tag = tag_q.pop_front();
        check_value({tag, " latency"}, exp_cyc, cycle);
        for (int i = 0; i < pe_pkg::MATRIX_W; i++) begin
            for (int j = 0; j < pe_pkg::MATRIX_W; j++) begin
                check_value($sformatf("%s prod[%0d][%0d]", tag, i, j),
                            exp_r[i][j].prod, results[i][j].prod);
                check_value($sformatf("%s row_off[%0d][%0d]", tag, i, j),
                            exp_r[i][j].row_off, results[i][j].row_off);
                check_value($sformatf("%s col_off[%0d][%0d]", tag, i, j),
                            exp_r[i][j].col_off, results[i][j].col_off);
                pass_sum += int'(results[i][j].prod);
            end
        end
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (out_valid) begin
            pass_pulses++;
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("ERROR: out_valid high at cycle %0d with no group in flight", cycle);
            end else begin
                check_pulse();
            end
        end
    end

    task automatic run_pass();
        int fc;
        int gap_max;
        logic [31:0] exp_pulses;
        logic [31:0] exp_sum;
        pe_pkg::group_t grp;
        fc = data_mem[ptr];
        gap_max = data_mem[ptr + 1];
        exp_pulses = data_mem[ptr + 2];
        exp_sum = data_mem[ptr + 3];
        ptr += 4;
        pass_num++;
        pass_pulses = 0;
        pass_sum = 0;
        idle_cycle();
        feature_count = fc[COUNT_W-1:0];
        for (int k = 0; k < pe_pkg::MATRIX_W; k++) begin
            insert_gap(gap_max);
            drive_weight(k, make_entry(ptr));
            ptr += ENTRY_WORDS;
        end
        for (int g = 0; g < fc; g++) begin
            insert_gap(gap_max);
            for (int j = 0; j < pe_pkg::MATRIX_W; j++) begin
                grp[j] = make_entry(ptr + ENTRY_WORDS * j);
            end
            ptr += ENTRY_WORDS * pe_pkg::MATRIX_W;
            drive_group(grp, $sformatf("pass %0d group %0d", pass_num, g));
        end
        idle_cycle();
        while (exp_q.size() != 0) begin
            idle_cycle();
        end
        // a few quiet cycles to catch stray pulses
        repeat (3) idle_cycle();
        check_value($sformatf("pass %0d pulse count", pass_num), exp_pulses, pass_pulses);
        check_value($sformatf("pass %0d product sum", pass_num), exp_sum, pass_sum);
    endtask

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        weight_in = '0;
        group_in = '0;
        feature_count = '0;
        seed = 32'h353b_2357;
        for (int k = 0; k < DATA_DEPTH; k++) begin
            data_mem[k] = '0;
        end
        for (int s = 0; s < pe_pkg::MATRIX_W; s++) begin
            model_weights[s] = '0;
            model_window[s] = '0;
        end
        $readmemh("testbench/pe_testdata.txt", data_mem);
        watchdog_cycles = count_records() * 20 + 200;

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("reset out_valid", 1'b0, out_valid);

        ptr = 0;
        pass_num = 0;
        while (ptr + 4 <= DATA_DEPTH && data_mem[ptr] != 0) begin
            run_pass();
        end
        if (pass_num == 0) begin
            other_errors++;
            $display("ERROR: no test passes were found in the data file");
        end

        $display("errors: %0d value mismatches, %0d other failures",
                 check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("ERROR: simulation timed out after %0d cycles", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== testbench/pe_testdata.txt ====
// pass header: feature_count gap_max expected_pulses expected_product_sum
// then 4 weight lines (value row col) and one line per group (value row col x 4)

// pass 1: back to back records
00000006 00000000 00000006 fffffffc
02 01 01
fd 01 02
01 02 01
04 7f 80
01 01 01  02 01 02  03 02 01  04 02 02
ff 03 00  05 00 03  00 80 7f  07 10 20
0a 05 05  ec 06 06  1e 07 07  d8 08 08
7f 80 80  80 7f 7f  01 00 00  ff ff ff
03 01 02  03 03 04  03 05 06  03 07 08
fb 20 21  06 22 23  f9 24 25  08 26 27

// pass 2: new weights, shorter stream, random gaps
00000003 00000003 00000003 00000155
ff 10 10
05 00 00
00 f0 0f
fe 40 c0
04 11 12  fc 13 14  08 15 16  01 17 18
64 00 ff  1b ff 00  ce 80 80  00 7f 7f
80 01 01  7f 02 02  02 03 03  02 04 04

// pass 3: signed extremes and wrapping offsets
00000002 00000002 00000002 00000102
80 7f 80
7f 80 7f
80 00 00
ff 81 7e
80 80 7f  80 7f 80  7f 00 ff  ff ff 00
80 ff ff  01 80 80  ff 7f 7f  7f 01 01

// end of passes
00000000 00000000 00000000 00000000

// ==== tb.f ====
logic/pe_pkg.sv
logic/pe_decode.sv
logic/pe_operand_store.sv
logic/pe_execute.sv
logic/sparse_conv_pe.sv
testbench/pe_props.sv
testbench/tb_sparse_conv_pe.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_sparse_conv_pe -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^Result: PASSED$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
